// File: common/uart_pkg.sv
package uart_pkg;

    // clock and bit rate
    localparam int CLK_HZ     = 10_000_000;
    localparam int BAUD       = 125_000;
    localparam int OVERSAMPLE = 16;                  // ticks per bit
    localparam int BAUD_DIV   = CLK_HZ / (BAUD * OVERSAMPLE);
    localparam int DIV_W      = $clog2(BAUD_DIV);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(BAUD_DIV - 1);

    // tick and bit counters inside a frame
    localparam int TICK_W = $clog2(OVERSAMPLE);
    localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(OVERSAMPLE - 1);
    localparam logic [TICK_W-1:0] TICK_MID  = TICK_W'(OVERSAMPLE / 2 - 1);

    // byte fifo
    localparam int DATA_W     = 8;
    localparam int FIFO_AW    = 2;
    localparam int FIFO_DEPTH = 2 ** FIFO_AW;
    localparam int BIT_W      = $clog2(DATA_W);
    localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(DATA_W - 1);

    // register index, paddr[3:2]
    localparam logic [1:0] ADDR_TXD  = 2'd0;
    localparam logic [1:0] ADDR_RXD  = 2'd1;
    localparam logic [1:0] ADDR_TXSR = 2'd2;
    localparam logic [1:0] ADDR_RXSR = 2'd3;

    // frame states, shared by transmitter and receiver
    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_START = 2'd1;
    localparam logic [1:0] ST_DATA  = 2'd2;
    localparam logic [1:0] ST_STOP  = 2'd3;

endpackage

// File: hdl/baud_tick_gen.sv
module baud_tick_gen (
    input  logic clk,
    input  logic reset,
    output logic tick
);

    logic [uart_pkg::DIV_W-1:0] cnt;

    // one tick per BAUD_DIV clocks, 16 per bit
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else begin
            if (cnt == uart_pkg::DIV_LAST) begin
                cnt  <= '0;
                tick <= 1'b1;
            end else begin
                cnt  <= cnt + 1'b1;
                tick <= 1'b0;
            end
        end
    end

endmodule

// File: hdl/byte_fifo.sv
module byte_fifo (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        push,
    input  logic                        pop,
    input  logic [uart_pkg::DATA_W-1:0] wdata,
    output logic [uart_pkg::DATA_W-1:0] rdata,
    output logic                        full,
    output logic                        empty
);

    logic [uart_pkg::DATA_W-1:0]  mem [uart_pkg::FIFO_DEPTH];
    logic [uart_pkg::FIFO_AW-1:0] wr_ptr, rd_ptr;
    logic [uart_pkg::FIFO_AW-1:0] wr_ptr_next, rd_ptr_next;
    logic                         full_next, empty_next;
    logic                         do_push, do_pop;

    assign do_push = push && !full;   // push when full is dropped
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    assign rdata = mem[rd_ptr];   // head shown without latency

    always_comb begin
        wr_ptr_next = wr_ptr;
        rd_ptr_next = rd_ptr;
        full_next   = full;
        empty_next  = empty;
        if (do_push) begin
            wr_ptr_next = wr_ptr + 1'b1;
        end
        if (do_pop) begin
            rd_ptr_next = rd_ptr + 1'b1;
        end
        // simultaneous push and pop keeps the level
        if (do_push && !do_pop) begin
            empty_next = 1'b0;
            full_next  = (wr_ptr_next == rd_ptr);
        end else if (do_pop && !do_push) begin
            full_next  = 1'b0;
            empty_next = (rd_ptr_next == wr_ptr);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            full   <= 1'b0;
            empty  <= 1'b1;
        end else begin
            wr_ptr <= wr_ptr_next;
            rd_ptr <= rd_ptr_next;
            full   <= full_next;
            empty  <= empty_next;
        end
    end

    a_flags_exclusive: assert property (
        @(posedge clk) disable iff (reset)
        !(full && empty)
    );

    // flags agree with the pointer compare
    a_flags_match_ptrs: assert property (
        @(posedge clk) disable iff (reset)
        (full || empty) == (wr_ptr == rd_ptr)
    );

endmodule

// File: hdl/uart_apb_periph.sv
module uart_apb_periph (
    input  logic        clk,
    input  logic        reset,
    input  logic [3:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    input  logic        rx,
    output logic        tx
);

    logic                       tick;
    logic                       tx_full, tx_empty, rx_full, rx_empty;
    logic                       tx_push, tx_pop, rx_push, rx_pop;
    logic [uart_pkg::DATA_W-1:0] tx_byte, tx_head, rx_byte, rx_head;

    uart_apb_regs u_regs (
        .clk     (clk),
        .reset   (reset),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .tx_full (tx_full),
        .tx_empty(tx_empty),
        .rx_full (rx_full),
        .rx_empty(rx_empty),
        .rx_head (rx_head),
        .tx_push (tx_push),
        .rx_pop  (rx_pop),
        .tx_byte (tx_byte)
    );

    byte_fifo u_tx_fifo (
        .clk(clk), .reset(reset), .push(tx_push), .pop(tx_pop), .wdata(tx_byte),
        .rdata(tx_head), .full(tx_full), .empty(tx_empty)
    );

    byte_fifo u_rx_fifo (
        .clk(clk), .reset(reset), .push(rx_push), .pop(rx_pop), .wdata(rx_byte),
        .rdata(rx_head), .full(rx_full), .empty(rx_empty)
    );

    baud_tick_gen u_baud (.clk(clk), .reset(reset), .tick(tick));

    uart_tx u_uart_tx (
        .clk(clk), .reset(reset), .tick(tick), .start(!tx_empty), .data(tx_head),
        .tx(tx), .tx_pop(tx_pop)
    );

    uart_rx u_uart_rx (
        .clk(clk), .reset(reset), .tick(tick), .rx(rx),
        .rx_byte(rx_byte), .rx_push(rx_push)
    );

endmodule

// File: hdl/uart_apb_regs.sv
module uart_apb_regs (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [3:0]                  paddr,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [31:0]                 pwdata,
    output logic [31:0]                 prdata,
    output logic                        pready,
    input  logic                        tx_full,
    input  logic                        tx_empty,
    input  logic                        rx_full,
    input  logic                        rx_empty,
    input  logic [uart_pkg::DATA_W-1:0] rx_head,
    output logic                        tx_push,
    output logic                        rx_pop,
    output logic [uart_pkg::DATA_W-1:0] tx_byte
);

    logic [1:0] idx;
    logic       access;

    assign idx    = paddr[3:2];
    assign access = psel && penable;

    // one wait state, pready in the second access cycle only
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pready <= 1'b0;
        end else begin
            pready <= access && !pready;
        end
    end

    // side effects land in the completing cycle
    assign tx_push = pready && access && pwrite && (idx == uart_pkg::ADDR_TXD);
    assign rx_pop  = pready && access && !pwrite && (idx == uart_pkg::ADDR_RXD) && !rx_empty;
    assign tx_byte = pwdata[uart_pkg::DATA_W-1:0];

    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            case (idx)
                uart_pkg::ADDR_RXD: begin
                    if (!rx_empty) begin
                        prdata[uart_pkg::DATA_W-1:0] = rx_head;
                    end
                end
                uart_pkg::ADDR_TXSR: prdata[1:0] = {tx_full, tx_empty};
                uart_pkg::ADDR_RXSR: prdata[1:0] = {rx_full, rx_empty};
                default: prdata = '0;     // txd is write only
            endcase
        end
    end

    // master must drop to setup or idle after each completed transfer
    a_access_ends: assert property (
        @(posedge clk) disable iff (reset)
        (pready && access) |=> !penable
    );

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the UART APB testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module uart_apb_tb \
    -Mdir obj_dir -o sim_uart

./obj_dir/sim_uart > sim.log
cat sim.log

if grep -q "TEST FAIL" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
echo "simulation finished without failures"

// File: tb/uart_apb_tb.sv
module uart_apb_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int BIT_CLKS   = uart_pkg::BAUD_DIV * uart_pkg::OVERSAMPLE;
    localparam int FRAME_CLKS = 10 * BIT_CLKS;   // start, 8 data, stop

    logic        clk;
    logic        reset;
    logic [3:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        rx;
    logic        tx;
    logic        loopback;
    logic        rx_line;     // serial line driven by the testbench

    int   value_errs = 0;
    int   proto_errs = 0;
    int   wd_cycles = 0;
    logic wd_armed = 1'b0;

    logic [uart_pkg::DATA_W-1:0] tx_seen[$];   // bytes caught by the tx monitor
    string       name_q[$];
    string       op_q[$];
    logic [31:0] arg_q[$];
    logic [31:0] exp_q[$];

    assign rx = loopback ? tx : rx_line;

    uart_apb_periph u_dut (
        .clk    (clk),
        .reset  (reset),
        .paddr  (paddr),
        .psel   (psel),
        .penable(penable),
        .pwrite (pwrite),
        .pwdata (pwdata),
        .prdata (prdata),
        .pready (pready),
        .rx     (rx),
        .tx     (tx)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic compare_byte(input string name, input logic [uart_pkg::DATA_W-1:0] exp_v,
                                input logic [uart_pkg::DATA_W-1:0] act_v);
        if (exp_v !== act_v) begin
            value_errs++;
            $display("Error %s: expected %02h, actual %02h", name, exp_v, act_v);
        end
    endtask

    task automatic compare_status(input string name, input logic [1:0] exp_v,
                                  input logic [1:0] act_v);
        if (exp_v !== act_v) begin
            value_errs++;
            $display("Error %s: expected full/empty %b, actual %b", name, exp_v, act_v);
        end
    endtask

    // setup, access, then hold until pready
    task automatic apb_access(input logic [3:0] addr, input logic wr, input logic [31:0] wdata,
                              output logic [31:0] rdata);
        int waited;
        waited = 0;
        repeat ($urandom % 3) @(posedge clk);   // random idle gap
        @(posedge clk);
        paddr   <= addr;
        pwrite  <= wr;
        pwdata  <= wdata;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        while (!pready && waited < 16) begin
            @(negedge clk);
            waited++;
        end
        if (!pready) begin
            proto_errs++;
            $display("APB access to address %h never got pready", addr);
        end else if (waited != 1) begin
            proto_errs++;
            $display("APB access to address %h took %0d wait states instead of one",
                     addr, waited);
        end
        rdata = prdata;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] wdata);
        logic [31:0] unused;
        apb_access(addr, 1'b1, wdata, unused);
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] rdata);
        apb_access(addr, 1'b0, 32'h0, rdata);
    endtask

    task automatic drive_bit(input logic v);
        @(posedge clk);
        rx_line <= v;
        repeat (BIT_CLKS - 1) @(posedge clk);
    endtask

    task automatic send_serial(input logic [uart_pkg::DATA_W-1:0] b, input logic stop_ok);
        drive_bit(1'b0);
        for (int i = 0; i < uart_pkg::DATA_W; i++) begin
            drive_bit(b[i]);
        end
        drive_bit(stop_ok);
        @(posedge clk);
        rx_line <= 1'b1;
        repeat (BIT_CLKS / 2) @(posedge clk);   // short idle before the next frame
    endtask

    // mid-bit sampling of tx
    initial begin : tx_monitor
        logic [uart_pkg::DATA_W-1:0] shift;
        forever begin
            @(negedge clk);
            if (!reset && !tx) begin
                repeat (BIT_CLKS / 2) @(negedge clk);
                if (tx) begin
                    proto_errs++;
                    $display("tx start bit went high before its mid-point");
                end
                for (int i = 0; i < uart_pkg::DATA_W; i++) begin
                    repeat (BIT_CLKS) @(negedge clk);
                    shift = {tx, shift[uart_pkg::DATA_W-1:1]};   // lsb first
                end
                repeat (BIT_CLKS) @(negedge clk);
                if (!tx) begin
                    proto_errs++;
                    $display("tx frame with byte %02h is missing its stop bit", shift);
                end
                tx_seen.push_back(shift);
            end
        end
    end

    initial begin : watchdog
        wait (wd_armed);
        repeat (wd_cycles) @(posedge clk);
        $display("run timed out after %0d cycles", wd_cycles);
        $display("TEST FAIL");
        $finish;
    end

    initial begin : run_tests
        int              fd;
        int              n;
        int              frames;
        int              waited;
        string           line;
        string           op;
        logic [8*16-1:0] name_v;
        logic [8*16-1:0] op_v;
        logic [31:0]     arg;
        logic [31:0]     expv;
        logic [31:0]     rdata;

        void'($urandom(32'h2965));
        reset    = 1'b1;
        paddr    = '0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        pwdata   = '0;
        rx_line  = 1'b1;
        loopback = 1'b1;
        frames   = 0;

        fd = $fopen("tb/uart_patterns.txt", "r");
        if (fd == 0) begin
            proto_errs++;
            $display("could not open tb/uart_patterns.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.substr(0, 0) != "#") begin
                    n = $sscanf(line, "%s %s %h %h", name_v, op_v, arg, expv);
                    if (n == 4) begin
                        op = string'(op_v);
                        name_q.push_back(string'(name_v));
                        op_q.push_back(op);
                        arg_q.push_back(arg);
                        exp_q.push_back(expv);
                        if (op == "wait" || op == "quiet") begin
                            frames += int'(arg);
                        end else if (op == "ser" || op == "exp") begin
                            frames += 1;
                        end
                    end
                end
            end
            $fclose(fd);
        end
        if (name_q.size() == 0) begin
            proto_errs++;
            $display("no test steps were loaded");
        end
        wd_cycles = frames * FRAME_CLKS + 2000;
        wd_armed  = 1'b1;

        repeat (16) @(posedge clk);
        reset <= 1'b0;

        foreach (name_q[i]) begin
            op   = op_q[i];
            arg  = arg_q[i];
            expv = exp_q[i];
            if (op == "lb") begin
                @(posedge clk);
                loopback <= arg[0];
            end else if (op == "wr") begin
                apb_write(arg[3:0], expv);
            end else if (op == "rd") begin
                apb_read(arg[3:0], rdata);
                if (arg[3:2] == uart_pkg::ADDR_RXD) begin
                    compare_byte(name_q[i], expv[uart_pkg::DATA_W-1:0],
                                 rdata[uart_pkg::DATA_W-1:0]);
                end else begin
                    compare_status(name_q[i], expv[1:0], rdata[1:0]);
                end
            end else if (op == "wait" || op == "quiet") begin
                repeat (arg * FRAME_CLKS) @(posedge clk);
                if (op == "quiet" && tx_seen.size() != 0) begin
                    proto_errs++;
                    $display("%s: %0d unexpected byte(s) sent on tx", name_q[i], tx_seen.size());
                    tx_seen.delete();
                end
            end else if (op == "ser") begin
                send_serial(arg[uart_pkg::DATA_W-1:0], expv[0]);
            end else if (op == "exp") begin
                waited = 0;
                while (tx_seen.size() == 0 && waited < 2 * FRAME_CLKS) begin
                    @(negedge clk);
                    waited++;
                end
                if (tx_seen.size() == 0) begin
                    proto_errs++;
                    $display("%s: no byte arrived on tx", name_q[i]);
                end else begin
                    compare_byte(name_q[i], expv[uart_pkg::DATA_W-1:0], tx_seen.pop_front());
                end
            end else begin
                proto_errs++;
                $display("%s: unknown step %s", name_q[i], op);
            end
        end

        $display("errors: %0d value mismatches, %0d protocol errors", value_errs, proto_errs);
        if (value_errs == 0 && proto_errs == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: tb/uart_patterns.txt
# name op arg expected, arg and expected in hex
# lb on 0 | wr paddr byte | rd paddr value | wait/quiet frames 0 | ser byte stop_ok | exp 0 byte
setup       lb    1  0
reset_txsr  rd    8  01
reset_rxsr  rd    c  01
reset_rxd   rd    4  00
format_tx   wr    0  a5
format_tx   exp   0  a5
format_rx   wait  1  0
format_rx   rd    4  a5
loop_tx     wr    0  11
loop_tx     wr    0  22
loop_tx     wr    0  33
loop_tx     wr    0  44
loop_tx     exp   0  11
loop_tx     exp   0  22
loop_tx     exp   0  33
loop_tx     exp   0  44
loop_full   wait  1  0
loop_full   rd    c  02
loop_rxd    rd    4  11
loop_rxd    rd    4  22
loop_rxd    rd    4  33
loop_rxd    rd    4  44
loop_empty  rd    c  01
bp_setup    lb    0  0
bp_fill     wr    0  61
bp_fill     wr    0  62
bp_fill     wr    0  63
bp_fill     wr    0  64
bp_full     rd    8  02
bp_drop     wr    0  65
bp_tx       exp   0  61
bp_tx       exp   0  62
bp_tx       exp   0  63
bp_tx       exp   0  64
bp_quiet    quiet 2  0
bp_empty    rd    8  01
rx_badstop  ser   3c 0
rx_badstop  rd    c  01
rx_fill     ser   a1 1
rx_fill     ser   a2 1
rx_fill     ser   a3 1
rx_fill     ser   a4 1
rx_fill     ser   a5 1
rx_full     rd    c  02
rx_rxd      rd    4  a1
rx_rxd      rd    4  a2
rx_rxd      rd    4  a3
rx_rxd      rd    4  a4
rx_empty    rd    c  01

// File: uart/uart_rx.sv
module uart_rx (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        tick,
    input  logic                        rx,
    output logic [uart_pkg::DATA_W-1:0] rx_byte,
    output logic                        rx_push
);

    logic                        rx_s1, rx_s2, rx_d;
    logic [1:0]                  state;
    logic [uart_pkg::TICK_W-1:0] tick_cnt;
    logic [uart_pkg::BIT_W-1:0]  bit_cnt;
    logic [uart_pkg::DATA_W-1:0] shreg;
    logic                        bit_end, mid_start;

    assign bit_end   = tick && (tick_cnt == uart_pkg::TICK_LAST);
    assign mid_start = tick && (tick_cnt == uart_pkg::TICK_MID);
    assign rx_byte   = shreg;

    // two-flop sync plus a delayed copy for edge detect
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rx_s1 <= 1'b1;
            rx_s2 <= 1'b1;
            rx_d  <= 1'b1;
        end else begin
            rx_s1 <= rx;
            rx_s2 <= rx_s1;
            rx_d  <= rx_s2;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= uart_pkg::ST_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            rx_push  <= 1'b0;
        end else begin
            rx_push <= 1'b0;
            if (tick) begin
                tick_cnt <= tick_cnt + 1'b1;
            end
            case (state)
                uart_pkg::ST_IDLE: begin
                    tick_cnt <= '0;
                    // falling edge only, a low line after a bad stop is ignored
                    if (rx_d && !rx_s2) begin
                        state <= uart_pkg::ST_START;
                    end
                end
                uart_pkg::ST_START: begin
                    if (mid_start) begin
                        tick_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= rx_s2 ? uart_pkg::ST_IDLE : uart_pkg::ST_DATA;
                    end
                end
                uart_pkg::ST_DATA: begin
                    if (bit_end) begin   // mid-point of data bit
                        shreg <= {rx_s2, shreg[uart_pkg::DATA_W-1:1]};
                        if (bit_cnt == uart_pkg::BIT_LAST) begin
                            state <= uart_pkg::ST_STOP;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    if (bit_end) begin
                        rx_push <= rx_s2;   // bad stop bit drops the byte
                        state   <= uart_pkg::ST_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

// File: uart/uart_tx.sv
module uart_tx (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        tick,
    input  logic                        start,
    input  logic [uart_pkg::DATA_W-1:0] data,
    output logic                        tx,
    output logic                        tx_pop
);

    logic [1:0]                  state;
    logic [uart_pkg::TICK_W-1:0] tick_cnt;
    logic [uart_pkg::BIT_W-1:0]  bit_cnt;
    logic [uart_pkg::DATA_W-1:0] shreg;
    logic                        bit_end;

    assign bit_end = tick && (tick_cnt == uart_pkg::TICK_LAST);
    assign tx_pop  = (state == uart_pkg::ST_STOP) && bit_end;   // head is done

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= uart_pkg::ST_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            tx       <= 1'b1;
        end else begin
            if (state == uart_pkg::ST_IDLE) begin
                tick_cnt <= '0;
            end else if (tick) begin
                tick_cnt <= bit_end ? '0 : tick_cnt + 1'b1;
            end
            case (state)
                uart_pkg::ST_IDLE: begin
                    if (start && tick) begin   // frame aligned to a tick
                        state <= uart_pkg::ST_START;
                        shreg <= data;
                        tx    <= 1'b0;
                    end
                end
                uart_pkg::ST_START: begin
                    if (bit_end) begin
                        state   <= uart_pkg::ST_DATA;
                        bit_cnt <= '0;
                        tx      <= shreg[0];
                    end
                end
                uart_pkg::ST_DATA: begin
                    if (bit_end) begin
                        shreg <= shreg >> 1;
                        if (bit_cnt == uart_pkg::BIT_LAST) begin
                            state <= uart_pkg::ST_STOP;
                            tx    <= 1'b1;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            tx      <= shreg[1];     // lsb first
                        end
                    end
                end
                default: begin
                    if (bit_end) begin
                        state <= uart_pkg::ST_IDLE;
                    end
                end
            endcase
        end
    end

    a_idle_mark: assert property (
        @(posedge clk) disable iff (reset)
        (state == uart_pkg::ST_IDLE) |-> tx
    );

endmodule

// File: vlog.f
common/uart_pkg.sv
hdl/byte_fifo.sv
hdl/baud_tick_gen.sv
hdl/uart_apb_regs.sv
uart/uart_tx.sv
uart/uart_rx.sv
hdl/uart_apb_periph.sv
tb/uart_apb_tb.sv
